// File: include/sram_share_consts.svh
// Size constants of the shared word memory, included by the RTL and the testbench
`ifndef SRAM_SHARE_CONSTS_SVH
`define SRAM_SHARE_CONSTS_SVH

// ------------------------------
// Memory geometry
// ------------------------------

// Word address width, 1024 words of 32 bits
`define SRAM_AW 10

// Depth in words
`define SRAM_WORDS (1 << `SRAM_AW)

// ------------------------------
// Bus side
// ------------------------------

// APB byte address width
`define APB_AW 32

`endif

// File: hdl/sram_share_pkg.sv
// Shared types of the two-port memory, referenced by scoped names from every RTL module
`include "sram_share_consts.svh"

package sram_share_pkg;

  // ------------------------------
  // Data path vectors
  // ------------------------------

  // One memory word, also the APB data width
  typedef logic [31:0] word_t;

  // Byte write strobe, one bit per lane
  typedef logic [3:0] strb_t;

  // Word index into the memory
  typedef logic [`SRAM_AW-1:0] waddr_t;

  // APB byte address
  typedef logic [`APB_AW-1:0] paddr_t;

  // ------------------------------
  // Port FSM
  // ------------------------------
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_REQ,
    PORT_DONE
  } port_state_t;

endpackage

// File: hdl/byte_sram.sv
// Block-RAM style word memory with byte lane writes and a pipelined read, driven by the arbiter
`timescale 1ns/1ps
`include "sram_share_consts.svh"

module byte_sram #(
  parameter int aw = `SRAM_AW
) (
  input  logic                   CLK,
  input  logic                   cs,
  input  sram_share_pkg::waddr_t addr,
  input  sram_share_pkg::word_t  wdata,
  input  sram_share_pkg::strb_t  wren,
  output sram_share_pkg::word_t  rdata
);

  localparam int depth = 1 << aw;

  // Storage, contents unknown until written
  sram_share_pkg::word_t mem [0:depth-1];

  // Read pipeline registers
  logic [aw-1:0]         addr_q;
  logic                  cs_q;
  sram_share_pkg::strb_t lane_we;

  // Strobes only count while selected
  assign lane_we = wren & {4{cs}};

  // One write process per byte lane so synthesis maps to byte-enable BRAM
  for (genvar i = 0; i < 4; i++) begin : g_lane
    always @(posedge CLK) begin
      if (lane_we[i]) begin
        mem[addr[aw-1:0]][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // Address and select captured together, read happens one edge later
  always_ff @(posedge CLK) begin
    addr_q <= addr[aw-1:0];
    cs_q   <= cs;
  end

  // Zero when the previous cycle had no access
  assign rdata = cs_q ? mem[addr_q] : '0;

  // Arbiter must never present strobes without a grant
  a_wren_cs: assert property (@(posedge CLK) (wren != '0) |-> cs)
    else $error("byte_sram: write strobes without chip select");

endmodule

// File: hdl/sram_arbiter.sv
// Round-robin arbiter that grants one of two port requests per cycle and drives the memory
`timescale 1ns/1ps

module sram_arbiter (
  input  logic                   CLK,
  input  logic                   rst_n,

  // Port a request
  input  logic                   a_req,
  input  sram_share_pkg::waddr_t a_addr,
  input  sram_share_pkg::word_t  a_wdata,
  input  sram_share_pkg::strb_t  a_wren,

  // Port b request
  input  logic                   b_req,
  input  sram_share_pkg::waddr_t b_addr,
  input  sram_share_pkg::word_t  b_wdata,
  input  sram_share_pkg::strb_t  b_wren,

  // Grants back to the ports
  output logic                   a_gnt,
  output logic                   b_gnt,

  // Memory side
  output logic                   cs,
  output sram_share_pkg::waddr_t addr,
  output sram_share_pkg::word_t  wdata,
  output sram_share_pkg::strb_t  wren
);

  // High when port b won the last arbitration
  logic last_b;

  // ------------------------------
  // Grant logic
  // ------------------------------

  // Port a wins when alone or when b had the last turn
  assign a_gnt = a_req & (~b_req | last_b);

  // Port b wins when alone or when a had the last turn
  assign b_gnt = b_req & (~a_req | ~last_b);

  // Reset to "b last" so port a goes first
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      last_b <= 1'b1;
    end else if (a_gnt) begin
      last_b <= 1'b0;
    end else if (b_gnt) begin
      last_b <= 1'b1;
    end
  end

  // ------------------------------
  // Memory mux
  // ------------------------------

  assign cs = a_gnt | b_gnt;

  // Address and data follow the winner, don't care when idle
  assign addr  = b_gnt ? b_addr  : a_addr;
  assign wdata = b_gnt ? b_wdata : a_wdata;

  // Strobes forced low with no grant
  always_comb begin
    if (a_gnt) begin
      wren = a_wren;
    end else if (b_gnt) begin
      wren = b_wren;
    end else begin
      wren = '0;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  a_one_hot: assert property (@(posedge CLK) disable iff (!rst_n) !(a_gnt && b_gnt))
    else $error("sram_arbiter: both ports granted");

  // Ports hold req until granted, so a loser is served next cycle
  a_fair_a: assert property (@(posedge CLK) disable iff (!rst_n) (a_req && !a_gnt) |=> a_gnt)
    else $error("sram_arbiter: port a starved");

  a_fair_b: assert property (@(posedge CLK) disable iff (!rst_n) (b_req && !b_gnt) |=> b_gnt)
    else $error("sram_arbiter: port b starved");

endmodule

// File: hdl/apb_sram_port.sv
// APB slave port that turns one transfer into a memory request and completes it after the grant
`timescale 1ns/1ps
`include "sram_share_consts.svh"

module apb_sram_port (
  input  logic                   CLK,
  input  logic                   rst_n,

  // APB slave side
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  sram_share_pkg::paddr_t paddr,
  input  sram_share_pkg::word_t  pwdata,
  input  sram_share_pkg::strb_t  pstrb,
  output logic                   pready,
  output sram_share_pkg::word_t  prdata,
  output logic                   pslverr,

  // Arbiter and memory side
  input  sram_share_pkg::word_t  mem_rdata,
  output logic                   req,
  output sram_share_pkg::waddr_t req_addr,
  output sram_share_pkg::word_t  req_wdata,
  output sram_share_pkg::strb_t  req_wren,
  input  logic                   gnt
);

  sram_share_pkg::port_state_t state;
  sram_share_pkg::port_state_t state_nxt;

  // Any upper address bit set means beyond the memory
  logic out_of_range;

  // ------------------------------
  // Address decode
  // ------------------------------

  // Byte address to word index, low two bits dropped
  assign req_addr     = paddr[`SRAM_AW+1:2];
  assign out_of_range = |paddr[`APB_AW-1:`SRAM_AW+2];

  // Reads carry no strobes
  assign req_wdata = pwdata;
  assign req_wren  = pwrite ? pstrb : '0;

  // ------------------------------
  // Transfer FSM
  // ------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      sram_share_pkg::PORT_IDLE: begin
        // In-range setup phase, request is up in the first access cycle
        if (psel && !penable && !out_of_range) begin
          state_nxt = sram_share_pkg::PORT_REQ;
        // Bad address finishes without touching memory
        end else if (psel && penable && out_of_range) begin
          state_nxt = sram_share_pkg::PORT_DONE;
        end
      end
      sram_share_pkg::PORT_REQ: begin
        if (gnt) begin
          state_nxt = sram_share_pkg::PORT_DONE;
        end
      end
      sram_share_pkg::PORT_DONE: begin
        state_nxt = sram_share_pkg::PORT_IDLE;
      end
      default: begin
        state_nxt = sram_share_pkg::PORT_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= sram_share_pkg::PORT_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  assign req     = (state == sram_share_pkg::PORT_REQ);
  assign pready  = (state == sram_share_pkg::PORT_DONE);
  assign pslverr = pready & out_of_range;

  // Memory output is valid exactly in the PORT_DONE cycle after a read grant
  assign prdata = mem_rdata;

  // Master must hold the address until the port answers
  a_paddr_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    (psel && penable && !pready) |=> $stable(paddr))
    else $error("apb_sram_port: paddr changed during access phase");

endmodule

// File: hdl/sram_share_top.sv
// Top level of the shared memory, two APB slave ports arbitrated onto one word memory
`timescale 1ns/1ps

module sram_share_top (
  input  logic                   CLK,
  input  logic                   rst_n,

  // APB port a
  input  logic                   a_psel,
  input  logic                   a_penable,
  input  logic                   a_pwrite,
  input  sram_share_pkg::paddr_t a_paddr,
  input  sram_share_pkg::word_t  a_pwdata,
  input  sram_share_pkg::strb_t  a_pstrb,
  output logic                   a_pready,
  output sram_share_pkg::word_t  a_prdata,
  output logic                   a_pslverr,

  // APB port b
  input  logic                   b_psel,
  input  logic                   b_penable,
  input  logic                   b_pwrite,
  input  sram_share_pkg::paddr_t b_paddr,
  input  sram_share_pkg::word_t  b_pwdata,
  input  sram_share_pkg::strb_t  b_pstrb,
  output logic                   b_pready,
  output sram_share_pkg::word_t  b_prdata,
  output logic                   b_pslverr
);

  // ------------------------------
  // Port to arbiter
  // ------------------------------
  logic                   a_req;
  logic                   a_gnt;
  sram_share_pkg::waddr_t a_req_addr;
  sram_share_pkg::word_t  a_req_wdata;
  sram_share_pkg::strb_t  a_req_wren;
  logic                   b_req;
  logic                   b_gnt;
  sram_share_pkg::waddr_t b_req_addr;
  sram_share_pkg::word_t  b_req_wdata;
  sram_share_pkg::strb_t  b_req_wren;

  // Arbiter to memory, read data fans out to both ports
  logic                   mem_cs;
  sram_share_pkg::waddr_t mem_addr;
  sram_share_pkg::word_t  mem_wdata;
  sram_share_pkg::strb_t  mem_wren;
  sram_share_pkg::word_t  mem_rdata;

  apb_sram_port port_a (
    .CLK(CLK), .rst_n(rst_n),
    .psel(a_psel), .penable(a_penable), .pwrite(a_pwrite),
    .paddr(a_paddr), .pwdata(a_pwdata), .pstrb(a_pstrb),
    .pready(a_pready), .prdata(a_prdata), .pslverr(a_pslverr),
    .mem_rdata(mem_rdata), .req(a_req), .req_addr(a_req_addr),
    .req_wdata(a_req_wdata), .req_wren(a_req_wren), .gnt(a_gnt)
  );

  apb_sram_port port_b (
    .CLK(CLK), .rst_n(rst_n),
    .psel(b_psel), .penable(b_penable), .pwrite(b_pwrite),
    .paddr(b_paddr), .pwdata(b_pwdata), .pstrb(b_pstrb),
    .pready(b_pready), .prdata(b_prdata), .pslverr(b_pslverr),
    .mem_rdata(mem_rdata), .req(b_req), .req_addr(b_req_addr),
    .req_wdata(b_req_wdata), .req_wren(b_req_wren), .gnt(b_gnt)
  );

  sram_arbiter arb0 (
    .CLK(CLK), .rst_n(rst_n),
    .a_req(a_req), .a_addr(a_req_addr), .a_wdata(a_req_wdata), .a_wren(a_req_wren),
    .b_req(b_req), .b_addr(b_req_addr), .b_wdata(b_req_wdata), .b_wren(b_req_wren),
    .a_gnt(a_gnt), .b_gnt(b_gnt),
    .cs(mem_cs), .addr(mem_addr), .wdata(mem_wdata), .wren(mem_wren)
  );

  byte_sram mem0 (
    .CLK(CLK), .cs(mem_cs), .addr(mem_addr),
    .wdata(mem_wdata), .wren(mem_wren), .rdata(mem_rdata)
  );

endmodule

// File: sim/tb_sram_share.sv
// Directed testbench of the shared memory, drives both APB ports of sram_share_top and checks data
`timescale 1ns/1ps
`include "sram_share_consts.svh"

module tb_sram_share;

  // Worst case per transfer is setup, three access cycles and one idle cycle
  localparam int xfer_cycles    = 5;
  localparam int max_xfers      = 80;
  localparam int timeout_cycles = 4 * (max_xfers * xfer_cycles + 10);

  logic                   CLK;
  logic                   rst_n;
  logic                   a_psel, a_penable, a_pwrite, a_pready, a_pslverr;
  logic                   b_psel, b_penable, b_pwrite, b_pready, b_pslverr;
  sram_share_pkg::paddr_t a_paddr, b_paddr;
  sram_share_pkg::word_t  a_pwdata, b_pwdata, a_prdata, b_prdata;
  sram_share_pkg::strb_t  a_pstrb, b_pstrb;

  // Reference model, one flag per word that has been written
  sram_share_pkg::word_t  ref_mem [0:`SRAM_WORDS-1];
  bit                     written [0:`SRAM_WORDS-1];
  sram_share_pkg::waddr_t written_q [$];

  integer seed = 32'hb65b_1b81;
  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt;

  sram_share_top dut0 (
    .CLK(CLK), .rst_n(rst_n),
    .a_psel(a_psel), .a_penable(a_penable), .a_pwrite(a_pwrite), .a_paddr(a_paddr),
    .a_pwdata(a_pwdata), .a_pstrb(a_pstrb), .a_pready(a_pready), .a_prdata(a_prdata),
    .a_pslverr(a_pslverr),
    .b_psel(b_psel), .b_penable(b_penable), .b_pwrite(b_pwrite), .b_paddr(b_paddr),
    .b_pwdata(b_pwdata), .b_pstrb(b_pstrb), .b_pready(b_pready), .b_prdata(b_prdata),
    .b_pslverr(b_pslverr)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // ------------------------------
  // Checks
  // ------------------------------

  task automatic compare_word(input sram_share_pkg::word_t got, exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: %s, got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic compare_int(input int got, exp, input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Fail at %0t: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic bound_cycles(input int got, limit, input string what);
    checks++;
    assert (got <= limit) else begin
      errors++;
      $display("Fail at %0t: %s took %0d access cycles, limit %0d", $time, what, got, limit);
    end
  endtask

  // ------------------------------
  // APB driver
  // ------------------------------

  task automatic drive_port(input bit port, sel, en, wr, input sram_share_pkg::paddr_t addr,
                            input sram_share_pkg::word_t wdata, input sram_share_pkg::strb_t strb);
    if (port) begin
      b_psel    = sel;
      b_penable = en;
      b_pwrite  = wr;
      b_paddr   = addr;
      b_pwdata  = wdata;
      b_pstrb   = strb;
    end else begin
      a_psel    = sel;
      a_penable = en;
      a_pwrite  = wr;
      a_paddr   = addr;
      a_pwdata  = wdata;
      a_pstrb   = strb;
    end
  endtask

  // Setup and access phase, outputs sampled mid-cycle, access cycles counted
  task automatic run_transfer(input bit port, wr, input sram_share_pkg::paddr_t addr,
                              input sram_share_pkg::word_t wdata, input sram_share_pkg::strb_t strb,
                              output sram_share_pkg::word_t rdata, output bit err,
                              output int cycles);
    bit done;
    done   = 1'b0;
    cycles = 0;
    @(posedge CLK);
    #1;
    drive_port(port, 1'b1, 1'b0, wr, addr, wdata, strb);
    @(posedge CLK);
    #1;
    drive_port(port, 1'b1, 1'b1, wr, addr, wdata, strb);
    while (!done) begin
      @(negedge CLK);
      cycles++;
      done = port ? b_pready : a_pready;
    end
    rdata = port ? b_prdata : a_prdata;
    err   = port ? b_pslverr : a_pslverr;
    @(posedge CLK);
    #1;
    drive_port(port, 1'b0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic apb_write(input bit port, input sram_share_pkg::paddr_t addr,
                           input sram_share_pkg::word_t data, input sram_share_pkg::strb_t strb,
                           output bit err, output int cycles);
    sram_share_pkg::word_t unused;
    run_transfer(port, 1'b1, addr, data, strb, unused, err, cycles);
  endtask

  task automatic apb_read(input bit port, input sram_share_pkg::paddr_t addr,
                          output sram_share_pkg::word_t data, output bit err, output int cycles);
    run_transfer(port, 1'b0, addr, '0, 4'h0, data, err, cycles);
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------

  function automatic sram_share_pkg::paddr_t word_addr(input sram_share_pkg::waddr_t idx);
    return sram_share_pkg::paddr_t'(idx) << 2;
  endfunction

  // Only strobed byte lanes take the new data
  task automatic model_write(input sram_share_pkg::waddr_t idx, input sram_share_pkg::word_t data,
                             input sram_share_pkg::strb_t strb);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        ref_mem[idx][8*i +: 8] = data[8*i +: 8];
      end
    end
    if (!written[idx]) begin
      written[idx] = 1'b1;
      written_q.push_back(idx);
    end
  endtask

  // In-range access checked against the model
  task automatic checked_op(input bit port, wr, input sram_share_pkg::waddr_t idx,
                            input sram_share_pkg::word_t data, input sram_share_pkg::strb_t strb);
    sram_share_pkg::word_t rd;
    sram_share_pkg::word_t exp;
    bit                    err;
    int                    cyc;
    exp = ref_mem[idx];
    run_transfer(port, wr, word_addr(idx), data, strb, rd, err, cyc);
    compare_int(err, 0, "pslverr on in-range access");
    bound_cycles(cyc, 3, "in-range access");
    if (wr) begin
      model_write(idx, data, strb);
    end else begin
      compare_word(rd, exp, "read data");
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(posedge CLK);
    #1;
    rst_n = 1'b1;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------

  task automatic write_read_port_a();
    sram_share_pkg::word_t data, rd;
    bit                    err;
    int                    cyc;
    data = $random(seed);
    apb_write(1'b0, word_addr(5), data, 4'hf, err, cyc);
    model_write(5, data, 4'hf);
    compare_int(cyc, 2, "uncontested write access cycles");
    compare_int(err, 0, "pslverr on write");
    apb_read(1'b0, word_addr(5), rd, err, cyc);
    compare_int(cyc, 2, "uncontested read access cycles");
    compare_word(rd, ref_mem[5], "read back on port a");
  endtask

  // Two partial writes from both ports merge into one word
  task automatic strobe_merge_shared();
    checked_op(1'b0, 1'b1, 9, 32'h1122_3344, 4'hf);
    checked_op(1'b0, 1'b1, 9, 32'haabb_ccdd, 4'b0101);
    checked_op(1'b1, 1'b1, 9, 32'hee00_0000, 4'b1000);
    checked_op(1'b1, 1'b0, 9, '0, 4'h0);
    checked_op(1'b0, 1'b0, 9, '0, 4'h0);
  endtask

  task automatic concurrent_ports();
    sram_share_pkg::word_t d0, d1;
    bit                    ea, eb;
    int                    ca, cb;
    apply_reset();
    d0 = $random(seed);
    d1 = $random(seed);
    // Same word from both sides, port a wins after reset so b's data stays
    fork
      apb_write(1'b0, word_addr(32), d0, 4'hf, ea, ca);
      apb_write(1'b1, word_addr(32), d1, 4'hf, eb, cb);
    join
    compare_int(ca, 2, "port a served first after reset");
    compare_int(cb, 3, "port b waits one cycle");
    model_write(32, d0, 4'hf);
    model_write(32, d1, 4'hf);
    fork
      checked_op(1'b0, 1'b1, 33, $random(seed), 4'hf);
      checked_op(1'b1, 1'b1, 34, $random(seed), 4'hf);
    join
    fork
      checked_op(1'b0, 1'b0, 34, '0, 4'h0);
      checked_op(1'b1, 1'b0, 33, '0, 4'h0);
    join
    checked_op(1'b0, 1'b0, 32, '0, 4'h0);
  endtask

  task automatic range_error();
    sram_share_pkg::word_t rd;
    bit                    err;
    int                    cyc;
    // Aliases word 5 if the upper bits were ignored
    apb_write(1'b0, 32'h0000_1000 | word_addr(5), 32'hdead_beef, 4'hf, err, cyc);
    compare_int(err, 1, "pslverr on out-of-range write");
    compare_int(cyc, 2, "out-of-range write access cycles");
    apb_read(1'b1, 32'h8000_0000, rd, err, cyc);
    compare_int(err, 1, "pslverr on out-of-range read");
    compare_int(cyc, 2, "out-of-range read access cycles");
    for (int i = 0; i < written_q.size(); i++) begin
      checked_op(i[0], 1'b0, written_q[i], '0, 4'h0);
    end
  endtask

  // Reads pick written words, first write of a word uses all lanes
  task automatic random_op(output bit wr, output sram_share_pkg::waddr_t idx,
                           output sram_share_pkg::word_t data, output sram_share_pkg::strb_t strb);
    logic [31:0] r;
    r    = $random(seed);
    wr   = r[31];
    idx  = wr ? r[`SRAM_AW-1:0] : written_q[r[15:0] % written_q.size()];
    data = $random(seed);
    strb = written[idx] ? r[19:16] : 4'hf;
  endtask

  task automatic random_traffic();
    bit                    wa, wb;
    sram_share_pkg::waddr_t ia, ib;
    sram_share_pkg::word_t  da, db;
    sram_share_pkg::strb_t  sa, sb;
    logic [31:0]            r;
    int                     ops;
    ops = 0;
    while (ops < 50) begin
      r = $random(seed);
      random_op(wa, ia, da, sa);
      random_op(wb, ib, db, sb);
      // Concurrent pairs only on different words
      if (r[0] && ia != ib) begin
        fork
          checked_op(1'b0, wa, ia, da, sa);
          checked_op(1'b1, wb, ib, db, sb);
        join
        ops += 2;
      end else begin
        checked_op(r[1], wa, ia, da, sa);
        ops += 1;
      end
    end
  endtask

  // ------------------------------
  // Run control
  // ------------------------------

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    drive_port(1'b0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    drive_port(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    apply_reset();
    write_read_port_a();
    strobe_merge_shared();
    concurrent_ports();
    range_error();
    random_traffic();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
hdl/sram_share_pkg.sv
hdl/byte_sram.sv
hdl/sram_arbiter.sv
hdl/apb_sram_port.sv
hdl/sram_share_top.sv
sim/tb_sram_share.sv

// File: Bender.yml
package:
  name: sram_share

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/sram_share_pkg.sv
      - hdl/byte_sram.sv
      - hdl/sram_arbiter.sv
      - hdl/apb_sram_port.sv
      - hdl/sram_share_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_sram_share.sv
